// File: Bender.yml
package:
  name: align_buffer

export_include_dirs:
  - include

sources:
  # Design sources, always part of the build
  - include_dirs:
      - include
    files:
      - design/align_pkg.sv
      - design/fetch_buf_if.sv
      - design/fetch_req_ctrl.sv
      - design/resp_fifo.sv
      - design/instr_aligner.sv
      - design/align_buffer_top.sv

  # Testbench sources, only for simulation runs
  - target: test
    include_dirs:
      - include
    files:
      - tb/align_buffer_assertions.sv
      - tb/tb_align_buffer.sv

// File: design/align_buffer_top.sv
`timescale 1ns/1ps
`default_nettype none

module align_buffer_top (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              pc_set_i,
  input  align_pkg::addr_t  branch_addr_i,
  input  logic              instr_req_i,
  output logic              fetch_valid_o,
  input  logic              fetch_ready_i,
  output align_pkg::addr_t  fetch_addr_o,
  input  logic              resp_valid_i,
  input  align_pkg::word_t  resp_data_i,
  output logic              instr_valid_o,
  input  logic              instr_ready_i,
  output align_pkg::instr_t instr_o,
  output align_pkg::addr_t  instr_addr_o,
  output logic              instr_compressed_o
);

  import align_pkg::*;

  // Filtered responses heading into the buffer
  logic  push;
  word_t push_word;

  // Buffer fill level fed back for request credit
  cnt_t  occupancy;

  // Head words and pop between buffer and aligner
  fetch_buf_if buf_if ();

  //////////////////////////////
  // Request side
  //////////////////////////////

  fetch_req_ctrl u_req_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .pc_set_i      (pc_set_i),
    .branch_addr_i (branch_addr_i),
    .instr_req_i   (instr_req_i),
    .fetch_valid_o (fetch_valid_o),
    .fetch_ready_i (fetch_ready_i),
    .fetch_addr_o  (fetch_addr_o),
    .resp_valid_i  (resp_valid_i),
    .resp_data_i   (resp_data_i),
    .occupancy_i   (occupancy),
    .push_o        (push),
    .push_word_o   (push_word)
  );

  //////////////////////////////
  // Buffer and aligner
  //////////////////////////////

  resp_fifo u_fifo (
    .clk         (clk),
    .rst_n       (rst_n),
    .pc_set_i    (pc_set_i),
    .push_i      (push),
    .push_word_i (push_word),
    .occupancy_o (occupancy),
    .buf_if      (buf_if.fifo)
  );

  instr_aligner u_aligner (
    .clk                (clk),
    .rst_n              (rst_n),
    .pc_set_i           (pc_set_i),
    .branch_addr_i      (branch_addr_i),
    .buf_if             (buf_if.aligner),
    .instr_valid_o      (instr_valid_o),
    .instr_ready_i      (instr_ready_i),
    .instr_o            (instr_o),
    .instr_addr_o       (instr_addr_o),
    .instr_compressed_o (instr_compressed_o)
  );

endmodule

`default_nettype wire

// File: design/align_pkg.sv
`default_nettype none
`include "align_params.svh"

package align_pkg;

  //////////////////////////////
  // Address and data words
  //////////////////////////////

  // Instruction or fetch address, always at least halfword aligned
  typedef logic [`ALIGN_ADDR_W-1:0] addr_t;

  // One word as returned by the instruction memory
  typedef logic [31:0] word_t;

  // Aligned instruction, compressed ones are zero-extended from 16 bits
  typedef logic [31:0] instr_t;

  //////////////////////////////
  // Buffer bookkeeping
  //////////////////////////////

  // Wide enough for a full buffer, so it also holds the outstanding count
  typedef logic [$clog2(`ALIGN_FIFO_DEPTH + 1)-1:0] cnt_t;

  // Index into the buffer entries
  typedef logic [$clog2(`ALIGN_FIFO_DEPTH)-1:0] ptr_t;

endpackage

`default_nettype wire

// File: design/fetch_buf_if.sv
`timescale 1ns/1ps
`default_nettype none

interface fetch_buf_if;

  import align_pkg::*;

  // Oldest buffered word and the one right behind it
  word_t head_word;
  word_t next_word;

  // Entry valid flags for the two words above
  logic  head_valid;
  logic  next_valid;

  // Removes the head entry at the next rising edge
  logic  pop;

  // Buffer side presents the two head words and takes the pop request
  modport fifo (
    output head_word,
    output next_word,
    output head_valid,
    output next_valid,
    input  pop
  );

  // The aligner reads both words and decides when the head is used up
  modport aligner (
    input  head_word,
    input  next_word,
    input  head_valid,
    input  next_valid,
    output pop
  );

endinterface

`default_nettype wire

// File: design/fetch_req_ctrl.sv
`timescale 1ns/1ps
`default_nettype none
`include "align_params.svh"

module fetch_req_ctrl (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             pc_set_i,
  input  align_pkg::addr_t branch_addr_i,
  input  logic             instr_req_i,
  output logic             fetch_valid_o,
  input  logic             fetch_ready_i,
  output align_pkg::addr_t fetch_addr_o,
  input  logic             resp_valid_i,
  input  align_pkg::word_t resp_data_i,
  input  align_pkg::cnt_t  occupancy_i,
  output logic             push_o,
  output align_pkg::word_t push_word_o
);

  import align_pkg::*;

  addr_t      next_addr_q;
  addr_t      branch_word;
  cnt_t       outst_q;
  cnt_t       flush_q;
  logic [2:0] credit_used;
  logic       seq_ok;
  logic       branch_ok;
  logic       fetch_accept;

  //////////////////////////////
  // Request issue
  //////////////////////////////

  // Memory is fetched in whole words so the branch target drops its low bits
  assign branch_word = {branch_addr_i[`ALIGN_ADDR_W-1:2], 2'b00};

  // Every in-flight word needs a free buffer slot when it returns
  assign credit_used = {1'b0, occupancy_i} + {1'b0, outst_q};

  // Sequential fetching obeys both the outstanding limit and the buffer credit
  assign seq_ok = instr_req_i &&
                  (outst_q < `ALIGN_MAX_OUTST) &&
                  (credit_used < `ALIGN_FIFO_DEPTH);

  // The buffer is emptied by a branch, so only the in-flight limit applies
  // A response arriving in the same cycle frees one slot of that limit
  assign branch_ok = (outst_q < `ALIGN_MAX_OUTST) || resp_valid_i;

  assign fetch_valid_o = pc_set_i ? branch_ok : seq_ok;
  assign fetch_addr_o  = pc_set_i ? branch_word : next_addr_q;
  assign fetch_accept  = fetch_valid_o && fetch_ready_i;

  //////////////////////////////
  // Response filtering
  //////////////////////////////

  // Stale words are swallowed while the flush counter is nonzero
  // A response in the branch cycle belongs to the old path as well
  assign push_o      = resp_valid_i && (flush_q == '0) && !pc_set_i;
  assign push_word_o = resp_data_i;

  // Next sequential word address
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      next_addr_q <= '0;
    end else if (pc_set_i) begin
      // If the target word was not taken this cycle it is requested next
      next_addr_q <= fetch_accept ? branch_word + addr_t'(4) : branch_word;
    end else if (fetch_accept) begin
      next_addr_q <= next_addr_q + addr_t'(4);
    end
  end

  // Counts every request in flight, including the ones to be discarded
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outst_q <= '0;
    end else begin
      outst_q <= outst_q + cnt_t'(fetch_accept) - cnt_t'(resp_valid_i);
    end
  end

  // Number of old-path responses still to be dropped
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      flush_q <= '0;
    end else if (pc_set_i) begin
      // All requests in flight at a branch are stale
      flush_q <= outst_q - cnt_t'(resp_valid_i);
    end else if (resp_valid_i && (flush_q != '0)) begin
      flush_q <= flush_q - cnt_t'(1);
    end
  end

endmodule

`default_nettype wire

// File: design/instr_aligner.sv
`timescale 1ns/1ps
`default_nettype none

module instr_aligner (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              pc_set_i,
  input  align_pkg::addr_t  branch_addr_i,
  fetch_buf_if.aligner      buf_if,
  output logic              instr_valid_o,
  input  logic              instr_ready_i,
  output align_pkg::instr_t instr_o,
  output align_pkg::addr_t  instr_addr_o,
  output logic              instr_compressed_o
);

  import align_pkg::*;

  addr_t       addr_q;
  logic        offset;
  logic [15:0] cur_half;
  logic        compressed;
  logic        avail;
  logic        xfer;

  //////////////////////////////
  // Halfword selection
  //////////////////////////////

  // Bit 1 of the address picks the upper or lower half of the head word
  assign offset   = addr_q[1];
  assign cur_half = offset ? buf_if.head_word[31:16] : buf_if.head_word[15:0];

  // RISC-V marks a full 32-bit instruction with both low bits set
  assign compressed = (cur_half[1:0] != 2'b11);

  // Only a full instruction in the upper half needs the following word too
  always_comb begin
    if (offset && !compressed) begin
      avail = buf_if.head_valid && buf_if.next_valid;
    end else begin
      avail = buf_if.head_valid;
    end
  end

  // Zero-extend compressed halves and join the two words for a split instruction
  always_comb begin
    if (compressed) begin
      instr_o = {16'h0000, cur_half};
    end else if (offset) begin
      instr_o = {buf_if.next_word[15:0], buf_if.head_word[31:16]};
    end else begin
      instr_o = buf_if.head_word;
    end
  end

  //////////////////////////////
  // Handshake and address
  //////////////////////////////

  // The branch cycle shows old-path data so it is never offered
  assign instr_valid_o      = avail && !pc_set_i;
  assign instr_addr_o       = addr_q;
  assign instr_compressed_o = compressed;
  assign xfer               = instr_valid_o && instr_ready_i;

  // The head word is used up unless a compressed instruction sat in its lower half
  assign buf_if.pop = xfer && (offset || !compressed);

  // Address of the instruction currently presented
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_q <= '0;
    end else if (pc_set_i) begin
      // An odd-halfword target starts in the upper half of its first word
      addr_q <= branch_addr_i;
    end else if (xfer) begin
      addr_q <= addr_q + (compressed ? addr_t'(2) : addr_t'(4));
    end
  end

endmodule

`default_nettype wire

// File: design/resp_fifo.sv
`timescale 1ns/1ps
`default_nettype none
`include "align_params.svh"

module resp_fifo (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             pc_set_i,
  input  logic             push_i,
  input  align_pkg::word_t push_word_i,
  output align_pkg::cnt_t  occupancy_o,
  fetch_buf_if.fifo        buf_if
);

  import align_pkg::*;

  word_t                        mem_q [`ALIGN_FIFO_DEPTH];
  logic [`ALIGN_FIFO_DEPTH-1:0] valid_q;
  ptr_t                         wptr_q;
  ptr_t                         rptr_q;
  ptr_t                         rptr2_q;
  cnt_t                         count_q;
  logic                         pop;

  // Pointers step through the entries and wrap after the last one
  function automatic ptr_t wrap_inc(input ptr_t p);
    if (p == ptr_t'(`ALIGN_FIFO_DEPTH - 1)) begin
      return '0;
    end
    return p + ptr_t'(1);
  endfunction

  //////////////////////////////
  // Head words to the aligner
  //////////////////////////////

  // Two words are shown so a full instruction crossing a word edge is read at once
  assign buf_if.head_word  = mem_q[rptr_q];
  assign buf_if.next_word  = mem_q[rptr2_q];
  assign buf_if.head_valid = valid_q[rptr_q];
  assign buf_if.next_valid = valid_q[rptr2_q];

  // The aligner releases the head word once it is used up
  assign pop = buf_if.pop;

  assign occupancy_o = count_q;

  //////////////////////////////
  // Storage and pointers
  //////////////////////////////

  // Word storage
  always_ff @(posedge clk) begin
    if (push_i) begin
      mem_q[wptr_q] <= push_word_i;
    end
  end

  // Valid flags, pointers and occupancy
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
      wptr_q  <= '0;
      rptr_q  <= '0;
      rptr2_q <= ptr_t'(1);
      count_q <= '0;
    end else if (pc_set_i) begin
      // A branch throws away everything that was buffered
      valid_q <= '0;
      wptr_q  <= '0;
      rptr_q  <= '0;
      rptr2_q <= ptr_t'(1);
      count_q <= '0;
    end else begin
      if (push_i) begin
        valid_q[wptr_q] <= 1'b1;
        wptr_q          <= wrap_inc(wptr_q);
      end
      if (pop) begin
        // Second read pointer always sits one entry ahead of the first
        valid_q[rptr_q] <= 1'b0;
        rptr_q          <= rptr2_q;
        rptr2_q         <= wrap_inc(rptr2_q);
      end
      count_q <= count_q + cnt_t'(push_i) - cnt_t'(pop);
    end
  end

endmodule

`default_nettype wire

// File: include/align_params.svh
`ifndef ALIGN_PARAMS_SVH
`define ALIGN_PARAMS_SVH

// Width of instruction and fetch addresses
`define ALIGN_ADDR_W 32

// Number of word entries in the response buffer
`define ALIGN_FIFO_DEPTH 3

// Largest number of fetch requests that may be in flight at once
`define ALIGN_MAX_OUTST 2

`endif

// File: sources.f
+incdir+include
design/align_pkg.sv
design/fetch_buf_if.sv
design/fetch_req_ctrl.sv
design/resp_fifo.sv
design/instr_aligner.sv
design/align_buffer_top.sv
tb/align_buffer_assertions.sv
tb/tb_align_buffer.sv

// File: tb/align_buffer_assertions.sv
`timescale 1ns/1ps
`default_nettype none
`include "align_params.svh"

module align_buffer_assertions (
  input logic            clk,
  input logic            rst_n,
  input logic            pc_set_i,
  input logic            fetch_valid_i,
  input logic            fetch_ready_i,
  input logic            resp_valid_i,
  input logic            push_i,
  input align_pkg::cnt_t occupancy_i,
  input logic            instr_valid_i
);

  // One bit wider than needed so an overrun is visible
  logic [2:0] outst_q;

  // Read by the testbench at the end of the run
  int fail_count = 0;

  // Requests in flight as seen on the memory bus
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outst_q <= '0;
    end else begin
      outst_q <= outst_q + 3'(fetch_valid_i && fetch_ready_i) - 3'(resp_valid_i);
    end
  end

  //////////////////////////////
  // Buffer properties
  //////////////////////////////

  // A full buffer has no credit left, so nothing may be written into it
  ap_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
    push_i |-> (occupancy_i < `ALIGN_FIFO_DEPTH))
  else begin
    $error("word pushed into a full buffer");
    fail_count = fail_count + 1;
  end

  // Branch flushes every buffered word
  ap_flush_empty: assert property (@(posedge clk) disable iff (!rst_n)
    pc_set_i |=> (occupancy_i == '0))
  else begin
    $error("buffer still holds words one cycle after a branch");
    fail_count = fail_count + 1;
  end

  //////////////////////////////
  // Handshake properties
  //////////////////////////////

  // Old-path data is never offered during the branch cycle
  ap_no_valid_branch: assert property (@(posedge clk) disable iff (!rst_n)
    pc_set_i |-> !instr_valid_i)
  else begin
    $error("instruction offered while a branch is taken");
    fail_count = fail_count + 1;
  end

  ap_outst_limit: assert property (@(posedge clk) disable iff (!rst_n)
    outst_q <= 3'(`ALIGN_MAX_OUTST))
  else begin
    $error("too many fetches in flight");
    fail_count = fail_count + 1;
  end

endmodule

bind align_buffer_top align_buffer_assertions u_assertions (
  .clk           (clk),
  .rst_n         (rst_n),
  .pc_set_i      (pc_set_i),
  .fetch_valid_i (fetch_valid_o),
  .fetch_ready_i (fetch_ready_i),
  .resp_valid_i  (resp_valid_i),
  .push_i        (push),
  .occupancy_i   (occupancy),
  .instr_valid_i (instr_valid_o)
);

`default_nettype wire

// File: tb/tb_align_buffer.sv
`timescale 1ns/1ps
`default_nettype none
`include "align_params.svh"

module tb_align_buffer;

  import align_pkg::*;

  localparam int MODE_IDLE   = 0;
  localparam int MODE_RANDOM = 1;
  localparam int MODE_DRAIN  = 2;

  logic   clk;
  logic   rst_n;
  logic   pc_set_i;
  addr_t  branch_addr_i;
  logic   instr_req_i;
  logic   fetch_valid_o;
  logic   fetch_ready_i;
  addr_t  fetch_addr_o;
  logic   resp_valid_i;
  word_t  resp_data_i;
  logic   instr_valid_o;
  logic   instr_ready_i;
  instr_t instr_o;
  addr_t  instr_addr_o;
  logic   instr_compressed_o;

  // Instruction memory indexed by address bits 7:2
  word_t  mem [64];

  // Requests accepted by the memory model in order, each with its response cycle
  addr_t  pend_addr [$];
  int     pend_due [$];
  int     last_due = -1;
  int     cyc = 0;
  integer seed;
  int     mode;
  bit     busy = 1'b0;

  // Reference model state
  addr_t  exp_addr = '0;
  addr_t  exp_fetch = '0;
  bit     booted = 1'b0;
  bit     hold = 1'b0;
  int     accepted = 0;
  int     returned = 0;
  int     xfer_count = 0;
  int     since_xfer = 0;
  int     err_count = 0;
  int     timeouts = 0;

  align_buffer_top uut (
    .clk                (clk),
    .rst_n              (rst_n),
    .pc_set_i           (pc_set_i),
    .branch_addr_i      (branch_addr_i),
    .instr_req_i        (instr_req_i),
    .fetch_valid_o      (fetch_valid_o),
    .fetch_ready_i      (fetch_ready_i),
    .fetch_addr_o       (fetch_addr_o),
    .resp_valid_i       (resp_valid_i),
    .resp_data_i        (resp_data_i),
    .instr_valid_o      (instr_valid_o),
    .instr_ready_i      (instr_ready_i),
    .instr_o            (instr_o),
    .instr_addr_o       (instr_addr_o),
    .instr_compressed_o (instr_compressed_o)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Reads the halfword at a halfword address and wraps over 256 bytes
  function automatic logic [15:0] half_at(input addr_t a);
    word_t w;
    w = mem[a[7:2]];
    return a[1] ? w[31:16] : w[15:0];
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (expected === actual) else begin
      $display("FAIL %s: expected %h, actual %h at %0t", name, expected, actual, $time);
      err_count = err_count + 1;
    end
  endtask

  //////////////////////////////
  // Memory model and stimulus
  //////////////////////////////

  always @(posedge clk) begin : stim
    int lat;
    int due;
    if (!rst_n) begin
      resp_valid_i  <= 1'b0;
      fetch_ready_i <= 1'b0;
    end else begin
      cyc = cyc + 1;
      // Request taken at this edge gets its in-order response 1 to 3 cycles later
      if (fetch_valid_o && fetch_ready_i) begin
        lat = 1 + ($unsigned($random(seed)) % 3);
        due = cyc + lat - 1;
        if (due <= last_due) begin
          due = last_due + 1;
        end
        last_due = due;
        pend_addr.push_back(fetch_addr_o);
        pend_due.push_back(due);
      end
      if ((pend_addr.size() > 0) && (pend_due[0] <= cyc)) begin
        resp_valid_i <= 1'b1;
        resp_data_i  <= mem[pend_addr[0][7:2]];
        void'(pend_addr.pop_front());
        void'(pend_due.pop_front());
      end else begin
        // Garbage on the data lines while no response is valid
        resp_valid_i <= 1'b0;
        resp_data_i  <= $random(seed);
      end
      fetch_ready_i <= ($unsigned($random(seed)) % 4) != 0;

      // Decode side alternates between light and heavy back-pressure
      if (mode != MODE_IDLE) begin
        if (($unsigned($random(seed)) % 16) == 0) begin
          busy = !busy;
        end
        if (busy) begin
          instr_ready_i <= ($unsigned($random(seed)) % 8) == 0;
        end else begin
          instr_ready_i <= ($unsigned($random(seed)) % 4) != 0;
        end
      end

      if (mode == MODE_RANDOM) begin
        if (($unsigned($random(seed)) % 32) == 0) begin
          // Halfword-aligned branch target anywhere in the wrapped memory
          pc_set_i      <= 1'b1;
          instr_req_i   <= 1'b1;
          branch_addr_i <= $unsigned($random(seed)) & 32'h0000_03fe;
        end else begin
          pc_set_i      <= 1'b0;
          instr_req_i   <= ($unsigned($random(seed)) % 8) != 0;
          branch_addr_i <= $random(seed);
        end
      end else if (mode == MODE_DRAIN) begin
        pc_set_i    <= 1'b0;
        instr_req_i <= 1'b0;
      end
    end
  end

  //////////////////////////////
  // Reference model and checks
  //////////////////////////////

  always @(posedge clk) begin : monitor
    logic [15:0] half;
    instr_t      exp_instr;
    logic        exp_c;
    addr_t       step;
    if (rst_n) begin
      since_xfer = since_xfer + 1;
      // Without a request or a branch the fetch port stays quiet
      if (!instr_req_i && !pc_set_i) begin
        check_value("fetch_idle", 0, fetch_valid_o);
      end
      if (!booted) begin
        check_value("valid_before_boot", 0, instr_valid_o);
      end

      // Fetches in flight as counted on the bus
      if (fetch_valid_o && fetch_ready_i) begin
        accepted = accepted + 1;
      end
      if (resp_valid_i) begin
        returned = returned + 1;
      end
      assert ((accepted - returned) <= `ALIGN_MAX_OUTST) else begin
        $display("FAIL outstanding_limit: expected at most %0d, actual %0d",
                 `ALIGN_MAX_OUTST, accepted - returned);
        err_count = err_count + 1;
      end

      // Fetch addresses start at the branch word and then step by four
      if (pc_set_i) begin
        check_value("branch_fetch_addr", {branch_addr_i[31:2], 2'b00}, fetch_addr_o);
        exp_fetch = {branch_addr_i[31:2], 2'b00};
        if (fetch_valid_o && fetch_ready_i) begin
          exp_fetch = exp_fetch + addr_t'(4);
        end
      end else if (fetch_valid_o && fetch_ready_i) begin
        check_value("seq_fetch_addr", exp_fetch, fetch_addr_o);
        exp_fetch = exp_fetch + addr_t'(4);
      end

      if (pc_set_i) begin
        check_value("valid_in_branch", 0, instr_valid_o);
        exp_addr = branch_addr_i;
        booted   = 1'b1;
        hold     = 1'b0;
      end else begin
        // A stalled instruction stays offered until it is taken
        if (hold) begin
          check_value("hold_valid", 1, instr_valid_o);
        end
        // Every offered instruction matches the model, so a stalled one cannot change
        if (instr_valid_o) begin
          half = half_at(exp_addr);
          if (half[1:0] != 2'b11) begin
            exp_instr = {16'h0000, half};
            exp_c     = 1'b1;
            step      = addr_t'(2);
          end else begin
            exp_instr = {half_at(exp_addr + addr_t'(2)), half};
            exp_c     = 1'b0;
            step      = addr_t'(4);
          end
          check_value("instr_addr", exp_addr, instr_addr_o);
          check_value("instr_data", exp_instr, instr_o);
          check_value("instr_compressed", exp_c, instr_compressed_o);
          if (instr_ready_i) begin
            exp_addr   = exp_addr + step;
            xfer_count = xfer_count + 1;
            since_xfer = 0;
          end
        end
        hold = instr_valid_o && !instr_ready_i;
      end
    end
  end

  //////////////////////////////
  // Run control
  //////////////////////////////

  task automatic wait_transfers(input int target, input int limit, output bit ok);
    int waited;
    waited = 0;
    ok     = 1'b1;
    while ((xfer_count < target) && ok) begin
      @(negedge clk);
      waited = waited + 1;
      if (waited > limit) begin
        $display("Timeout: only %0d of %0d instructions transferred", xfer_count, target);
        ok = 1'b0;
      end else if (since_xfer > 300) begin
        $display("Stall: no instruction transferred for 300 cycles");
        ok = 1'b0;
      end
    end
  endtask

  // Quiet means no response pending and nothing offered for a while
  task automatic wait_drain(input int limit, output bit ok);
    int waited;
    int quiet;
    waited = 0;
    quiet  = 0;
    ok     = 1'b1;
    while ((quiet < 16) && ok) begin
      @(negedge clk);
      waited = waited + 1;
      if (!instr_valid_o && !resp_valid_i && (pend_addr.size() == 0)) begin
        quiet = quiet + 1;
      end else begin
        quiet = 0;
      end
      if (waited > limit) begin
        $display("Timeout: buffer did not drain after requests stopped");
        ok = 1'b0;
      end
    end
  endtask

  initial begin : main
    bit    ok;
    word_t w;
    seed          = 38;
    mode          = MODE_IDLE;
    rst_n         = 1'b0;
    pc_set_i      = 1'b0;
    branch_addr_i = '0;
    instr_req_i   = 1'b0;
    fetch_ready_i = 1'b0;
    resp_valid_i  = 1'b0;
    resp_data_i   = '0;
    instr_ready_i = 1'b0;

    // Random words where about half the halfwords mark full instructions
    for (int i = 0; i < 64; i++) begin
      w = $random(seed);
      if ($random(seed) & 1) begin
        w[1:0] = 2'b11;
      end
      if ($random(seed) & 1) begin
        w[17:16] = 2'b11;
      end
      mem[i] = w;
    end

    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    // A few quiet cycles before the boot branch
    repeat (6) @(posedge clk);
    pc_set_i      <= 1'b1;
    branch_addr_i <= '0;
    instr_req_i   <= 1'b1;
    @(posedge clk);
    pc_set_i <= 1'b0;
    mode     <= MODE_RANDOM;

    wait_transfers(800, 32000, ok);
    if (ok) begin
      // Stop requesting and let the buffered words run out
      @(posedge clk);
      mode <= MODE_DRAIN;
      wait_drain(600, ok);
    end
    if (!ok) begin
      timeouts = timeouts + 1;
    end

    $display("Summary: %0d transfers, %0d errors, %0d assertion failures, %0d timeouts",
             xfer_count, err_count, uut.u_assertions.fail_count, timeouts);
    if ((err_count == 0) && (timeouts == 0) && (uut.u_assertions.fail_count == 0)) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
